// File: common/a23_trace_pkg.sv
// shared encodings and record types for the a23 execution tracer, imported by each trace block
package a23_trace_pkg;

	// ====================
	// instruction types
	// ====================
	localparam logic [3:0] REGOP    = 4'd0;
	localparam logic [3:0] MULT     = 4'd1;
	localparam logic [3:0] SWAP     = 4'd2;
	localparam logic [3:0] TRANS    = 4'd3;
	localparam logic [3:0] MTRANS   = 4'd4;
	localparam logic [3:0] BRANCH   = 4'd5;
	localparam logic [3:0] CODTRANS = 4'd6;
	localparam logic [3:0] COREGOP  = 4'd7;
	localparam logic [3:0] CORTRANS = 4'd8;
	localparam logic [3:0] SWI      = 4'd9;

	// data-processing opcodes, bits 24:21
	localparam logic [3:0] AND = 4'd0;
	localparam logic [3:0] EOR = 4'd1;
	localparam logic [3:0] SUB = 4'd2;
	localparam logic [3:0] RSB = 4'd3;
	localparam logic [3:0] ADD = 4'd4;
	localparam logic [3:0] ADC = 4'd5;
	localparam logic [3:0] SBC = 4'd6;
	localparam logic [3:0] RSC = 4'd7;
	localparam logic [3:0] TST = 4'd8;
	localparam logic [3:0] TEQ = 4'd9;
	localparam logic [3:0] CMP = 4'd10;
	localparam logic [3:0] CMN = 4'd11;
	localparam logic [3:0] ORR = 4'd12;
	localparam logic [3:0] MOV = 4'd13;
	localparam logic [3:0] BIC = 4'd14;
	localparam logic [3:0] MVN = 4'd15;

	// ====================
	// mnemonic codes
	// ====================
	// alphabetical, zero reserved for unknown
	localparam logic [5:0] MN_UNKNOWN = 6'd0;
	localparam logic [5:0] MN_ADC     = 6'd1;
	localparam logic [5:0] MN_ADD     = 6'd2;
	localparam logic [5:0] MN_AND     = 6'd3;
	localparam logic [5:0] MN_B       = 6'd4;
	localparam logic [5:0] MN_BIC     = 6'd5;
	localparam logic [5:0] MN_BL      = 6'd6;
	localparam logic [5:0] MN_CDP     = 6'd7;
	localparam logic [5:0] MN_CMN     = 6'd8;
	localparam logic [5:0] MN_CMP     = 6'd9;
	localparam logic [5:0] MN_EOR     = 6'd10;
	localparam logic [5:0] MN_LDC     = 6'd11;
	localparam logic [5:0] MN_LDM     = 6'd12;
	localparam logic [5:0] MN_LDR     = 6'd13;
	localparam logic [5:0] MN_LDRB    = 6'd14;
	localparam logic [5:0] MN_MCR     = 6'd15;
	localparam logic [5:0] MN_MLA     = 6'd16;
	localparam logic [5:0] MN_MOV     = 6'd17;
	localparam logic [5:0] MN_MRC     = 6'd18;
	localparam logic [5:0] MN_MUL     = 6'd19;
	localparam logic [5:0] MN_MVN     = 6'd20;
	localparam logic [5:0] MN_ORR     = 6'd21;
	localparam logic [5:0] MN_RSB     = 6'd22;
	localparam logic [5:0] MN_RSC     = 6'd23;
	localparam logic [5:0] MN_SBC     = 6'd24;
	localparam logic [5:0] MN_STC     = 6'd25;
	localparam logic [5:0] MN_STM     = 6'd26;
	localparam logic [5:0] MN_STR     = 6'd27;
	localparam logic [5:0] MN_STRB    = 6'd28;
	localparam logic [5:0] MN_SUB     = 6'd29;
	localparam logic [5:0] MN_SWI     = 6'd30;
	localparam logic [5:0] MN_SWP     = 6'd31;
	localparam logic [5:0] MN_SWPB    = 6'd32;
	localparam logic [5:0] MN_TEQ     = 6'd33;
	localparam logic [5:0] MN_TST     = 6'd34;

	// one instruction word, seen as data-processing or as single transfer
	typedef union packed {
		struct packed {
			logic [3:0] cond;
			logic [1:0] op_class;
			logic       imm;
			logic [3:0] opcode;
			logic       s;
			logic [3:0] rn;
			logic [3:0] rd;
			logic [3:0] rot;
			logic [7:0] imm8;
		} dp;
		struct packed {
			logic [3:0]  cond;
			logic [2:0]  op_class;
			logic        p;
			logic        u;
			logic        b;
			logic        w;
			logic        l;
			logic [3:0]  rn;
			logic [3:0]  rd;
			logic [11:0] offset12;
		} xfer;
	} a23_insn_u;

	typedef struct packed {
		logic [31:0] address;
		logic [31:0] instruction;
		logic [3:0]  insn_type;
		logic [5:0]  mnemonic;
		logic [31:0] imm32;
		logic        undefined;
	} exec_rec_t;

	typedef struct packed {
		logic [31:0] address;
		logic [31:0] data;
		logic [3:0]  byte_enable;
		logic        is_write;
	} mem_rec_t;

endpackage

// File: trace/a23_exec_stage.sv
// execute-stage register of the tracer, holds the accepted instruction and the delayed interrupt
`timescale 1ns/1ns

module a23_exec_stage (
	input  logic                     i_clk,
	input  logic                     i_rst,
	input  logic                     i_fetch_stall,
	input  logic                     i_instruction_valid,
	input  logic                     i_instruction_undefined,
	input  logic [31:0]              i_instruction,
	input  logic [31:0]              i_instruction_address,
	input  logic [2:0]               i_interrupt,
	output a23_trace_pkg::a23_insn_u o_insn,
	output logic [31:0]              o_address,
	output logic                     o_undefined,
	output logic                     o_issue,
	output logic                     o_suppress
);

	logic       accept;
	logic [2:0] interrupt_d1;

	// core moves an instruction on only when fetch is not stalled
	assign accept = !i_fetch_stall && i_instruction_valid;

	// ====================
	// held instruction
	// ====================
	always_ff @(posedge i_clk) begin
		if (accept) begin
			o_insn      <= i_instruction;
			o_address   <= i_instruction_address;
			o_undefined <= i_instruction_undefined;
		end
	end

	// issue pulse and interrupt delay
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_issue      <= 1'b0;
			interrupt_d1 <= 3'd0;
		end else begin
			o_issue      <= accept;
			interrupt_d1 <= i_interrupt;
		end
	end

	// an interrupt overrides the instruction just starting
	// levels 0 and 7 leave it alone
	assign o_suppress = (interrupt_d1 != 3'd0) && (interrupt_d1 != 3'd7);

endmodule

// File: trace/a23_insn_decoder.sv
// combinational decoder of the tracer, gives type, mnemonic code and expanded immediate
`timescale 1ns/1ns

module a23_insn_decoder (
	input  a23_trace_pkg::a23_insn_u i_insn,
	output logic [3:0]               o_type,
	output logic [5:0]               o_mnemonic,
	output logic [31:0]              o_imm32
);

	import a23_trace_pkg::*;

	logic [31:0] word;
	logic [31:0] imm_ext;
	logic [4:0]  rot_amt;
	logic [31:0] imm_rot;

	assign word = i_insn;

	// ====================
	// instruction type
	// ====================
	// order matters, swap and mult sit inside the regop space
	always_comb begin
		if ({word[27:23], word[21:20], word[11:4]} == {5'b00010, 2'b00, 8'b0000_1001})
			o_type = SWAP;
		else if ({word[27:22], word[7:4]} == {6'b000000, 4'b1001})
			o_type = MULT;
		else if (word[27:26] == 2'b00)
			o_type = REGOP;
		else if (word[27:26] == 2'b01)
			o_type = TRANS;
		else if (word[27:25] == 3'b100)
			o_type = MTRANS;
		else if (word[27:25] == 3'b101)
			o_type = BRANCH;
		else if (word[27:25] == 3'b110)
			o_type = CODTRANS;
		else if ({word[27:24], word[4]} == {4'b1110, 1'b0})
			o_type = COREGOP;
		else if ({word[27:24], word[4]} == {4'b1110, 1'b1})
			o_type = CORTRANS;
		else
			o_type = SWI;
	end

	// ====================
	// mnemonic
	// ====================
	always_comb begin
		o_mnemonic = MN_UNKNOWN;
		case (o_type)
			REGOP: begin
				case (i_insn.dp.opcode)
					AND: o_mnemonic = MN_AND;
					EOR: o_mnemonic = MN_EOR;
					SUB: o_mnemonic = MN_SUB;
					RSB: o_mnemonic = MN_RSB;
					ADD: o_mnemonic = MN_ADD;
					ADC: o_mnemonic = MN_ADC;
					SBC: o_mnemonic = MN_SBC;
					RSC: o_mnemonic = MN_RSC;
					TST: o_mnemonic = MN_TST;
					TEQ: o_mnemonic = MN_TEQ;
					CMP: o_mnemonic = MN_CMP;
					CMN: o_mnemonic = MN_CMN;
					ORR: o_mnemonic = MN_ORR;
					MOV: o_mnemonic = MN_MOV;
					BIC: o_mnemonic = MN_BIC;
					MVN: o_mnemonic = MN_MVN;
					default: o_mnemonic = MN_UNKNOWN;
				endcase
			end
			// bit 21 is the accumulate bit
			MULT:     o_mnemonic = word[21] ? MN_MLA : MN_MUL;
			SWAP:     o_mnemonic = i_insn.xfer.b ? MN_SWPB : MN_SWP;
			TRANS: begin
				case ({i_insn.xfer.b, i_insn.xfer.l})
					2'b00:   o_mnemonic = MN_STR;
					2'b01:   o_mnemonic = MN_LDR;
					2'b10:   o_mnemonic = MN_STRB;
					default: o_mnemonic = MN_LDRB;
				endcase
			end
			MTRANS:   o_mnemonic = i_insn.xfer.l ? MN_LDM : MN_STM;
			// link bit
			BRANCH:   o_mnemonic = word[24] ? MN_BL : MN_B;
			CODTRANS: o_mnemonic = i_insn.xfer.l ? MN_LDC : MN_STC;
			COREGOP:  o_mnemonic = MN_CDP;
			CORTRANS: o_mnemonic = i_insn.xfer.l ? MN_MRC : MN_MCR;
			SWI:      o_mnemonic = MN_SWI;
			default:  o_mnemonic = MN_UNKNOWN;
		endcase
	end

	// ====================
	// rotated immediate
	// ====================
	assign imm_ext = {24'h0, i_insn.dp.imm8};
	assign rot_amt = {i_insn.dp.rot, 1'b0};

	// shift by 32 clears the left part when rot is 0
	assign imm_rot = (imm_ext >> rot_amt) | (imm_ext << (6'd32 - {1'b0, rot_amt}));

	// only data-processing immediates carry one
	assign o_imm32 = (o_type == REGOP && i_insn.dp.imm) ? imm_rot : 32'h0;

endmodule

// File: trace/a23_mem_monitor.sv
// data-side monitor of the tracer, registers one record per data read or write
`timescale 1ns/1ns

module a23_mem_monitor (
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  logic                    i_fetch_stall,
	input  logic                    i_write_enable,
	input  logic                    i_data_access,
	input  logic [31:0]             i_address,
	input  logic [31:0]             i_write_data,
	input  logic [3:0]              i_byte_enable,
	input  logic [31:0]             i_read_data,
	output logic                    o_mem_valid,
	output a23_trace_pkg::mem_rec_t o_mem_rec
);

	logic is_write;
	logic is_read;

	// write wins when enable and access are both high
	assign is_write = !i_fetch_stall && i_write_enable;
	assign is_read  = !i_fetch_stall && i_data_access && !i_write_enable;

	always_ff @(posedge i_clk) begin
		if (i_rst)
			o_mem_valid <= 1'b0;
		else
			o_mem_valid <= is_write || is_read;
	end

	// record payload
	always_ff @(posedge i_clk) begin
		if (is_write || is_read) begin
			o_mem_rec.address     <= i_address;
			o_mem_rec.data        <= is_write ? i_write_data : i_read_data;
			// reads are always full word
			o_mem_rec.byte_enable <= is_write ? i_byte_enable : 4'hf;
			o_mem_rec.is_write    <= is_write;
		end
	end

endmodule

// File: trace/a23_tracer.sv
// top of the execution tracer, sits beside the core and emits execute and memory records
`timescale 1ns/1ns

module a23_tracer (
	input  logic                     i_clk,
	input  logic                     i_rst,
	input  logic                     i_fetch_stall,
	input  logic [31:0]              i_instruction,
	input  logic                     i_instruction_valid,
	input  logic                     i_instruction_undefined,
	input  logic [31:0]              i_instruction_address,
	input  logic [2:0]               i_interrupt,
	input  logic                     i_write_enable,
	input  logic                     i_data_access,
	input  logic [31:0]              i_address,
	input  logic [31:0]              i_write_data,
	input  logic [3:0]               i_byte_enable,
	input  logic [31:0]              i_read_data,
	output logic                     o_exec_valid,
	output a23_trace_pkg::exec_rec_t o_exec_rec,
	output logic                     o_mem_valid,
	output a23_trace_pkg::mem_rec_t  o_mem_rec
);

	import a23_trace_pkg::*;

	a23_insn_u   exec_insn;
	logic [31:0] exec_address;
	logic        exec_undefined;
	logic        exec_issue;
	logic        exec_suppress;
	logic [3:0]  dec_type;
	logic [5:0]  dec_mnemonic;
	logic [31:0] dec_imm32;

	// ====================
	// execute path
	// ====================
	a23_exec_stage u_exec_stage (
		.i_clk                   (i_clk),
		.i_rst                   (i_rst),
		.i_fetch_stall           (i_fetch_stall),
		.i_instruction_valid     (i_instruction_valid),
		.i_instruction_undefined (i_instruction_undefined),
		.i_instruction           (i_instruction),
		.i_instruction_address   (i_instruction_address),
		.i_interrupt             (i_interrupt),
		.o_insn                  (exec_insn),
		.o_address               (exec_address),
		.o_undefined             (exec_undefined),
		.o_issue                 (exec_issue),
		.o_suppress              (exec_suppress)
	);

	a23_insn_decoder u_insn_decoder (
		.i_insn     (exec_insn),
		.o_type     (dec_type),
		.o_mnemonic (dec_mnemonic),
		.o_imm32    (dec_imm32)
	);

	// no handshake, one strobe per issued instruction
	assign o_exec_valid = exec_issue && !exec_suppress;

	assign o_exec_rec.address     = exec_address;
	assign o_exec_rec.instruction = exec_insn;
	assign o_exec_rec.insn_type   = dec_type;
	assign o_exec_rec.mnemonic    = dec_mnemonic;
	assign o_exec_rec.imm32       = dec_imm32;
	assign o_exec_rec.undefined   = exec_undefined;

	// ====================
	// data path
	// ====================
	a23_mem_monitor u_mem_monitor (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_fetch_stall  (i_fetch_stall),
		.i_write_enable (i_write_enable),
		.i_data_access  (i_data_access),
		.i_address      (i_address),
		.i_write_data   (i_write_data),
		.i_byte_enable  (i_byte_enable),
		.i_read_data    (i_read_data),
		.o_mem_valid    (o_mem_valid),
		.o_mem_rec      (o_mem_rec)
	);

endmodule

// File: tests/a23_tracer_asserts.sv
// concurrent checks on the tracer strobes, bound into the a23_tracer top level
`timescale 1ns/1ns

module a23_tracer_asserts (
	input logic i_clk,
	input logic i_rst,
	input logic i_fetch_stall,
	input logic i_instruction_valid,
	input logic i_write_enable,
	input logic i_data_access,
	input logic o_exec_valid,
	input logic o_mem_valid
);

	// ====================
	// reset and strobes
	// ====================
	reset_clears_strobes: assert property (@(posedge i_clk)
		i_rst |=> (!o_exec_valid && !o_mem_valid))
		else $error("a valid output is high in the cycle after reset");

	// a stalled edge accepts nothing
	stall_blocks_exec: assert property (@(posedge i_clk) disable iff (i_rst)
		i_fetch_stall |=> !o_exec_valid)
		else $error("execute strobe after a stalled edge");

	exec_follows_accept: assert property (@(posedge i_clk) disable iff (i_rst)
		o_exec_valid |-> $past(!i_fetch_stall && i_instruction_valid))
		else $error("execute strobe without an accepted instruction");

	mem_follows_access: assert property (@(posedge i_clk) disable iff (i_rst)
		o_mem_valid |-> $past(!i_fetch_stall && (i_write_enable || i_data_access)))
		else $error("memory strobe without a qualifying access");

endmodule

bind a23_tracer a23_tracer_asserts u_tracer_asserts (
	.i_clk               (i_clk),
	.i_rst               (i_rst),
	.i_fetch_stall       (i_fetch_stall),
	.i_instruction_valid (i_instruction_valid),
	.i_write_enable      (i_write_enable),
	.i_data_access       (i_data_access),
	.o_exec_valid        (o_exec_valid),
	.o_mem_valid         (o_mem_valid)
);

// File: tests/a23_tracer_tb.sv
// testbench for the a23 tracer, replays rows of tests/trace_input.dat and checks both record streams
`timescale 1ns/1ns

module a23_tracer_tb;

	import a23_trace_pkg::*;

	localparam int TIMEOUT_CYCLES = 10;
	localparam int MAX_LINES      = 1000;

	logic        i_clk;
	logic        i_rst;
	logic        i_fetch_stall;
	logic [31:0] i_instruction;
	logic        i_instruction_valid;
	logic        i_instruction_undefined;
	logic [31:0] i_instruction_address;
	logic [2:0]  i_interrupt;
	logic        i_write_enable;
	logic        i_data_access;
	logic [31:0] i_address;
	logic [31:0] i_write_data;
	logic [3:0]  i_byte_enable;
	logic [31:0] i_read_data;
	logic        exec_valid;
	exec_rec_t   exec_rec;
	logic        mem_valid;
	mem_rec_t    mem_rec;

	// one vector row
	logic [31:0] row_kind;
	logic [31:0] row_stall;
	logic [31:0] row_irq;
	logic [31:0] row_undef;
	logic [31:0] row_word;
	logic [31:0] row_data;
	logic [31:0] row_be;
	logic [31:0] exp_type;
	logic [31:0] exp_mn;
	logic [31:0] exp_imm;
	logic [31:0] exp_data;
	logic [31:0] exp_be;
	logic [31:0] exp_wr;
	logic [31:0] exp_valid;

	int error_count;
	int test_count;
	int exec_seen;
	int mem_seen;
	int exec_expected;
	int mem_expected;

	a23_tracer i_dut (
		.i_clk                   (i_clk),
		.i_rst                   (i_rst),
		.i_fetch_stall           (i_fetch_stall),
		.i_instruction           (i_instruction),
		.i_instruction_valid     (i_instruction_valid),
		.i_instruction_undefined (i_instruction_undefined),
		.i_instruction_address   (i_instruction_address),
		.i_interrupt             (i_interrupt),
		.i_write_enable          (i_write_enable),
		.i_data_access           (i_data_access),
		.i_address               (i_address),
		.i_write_data            (i_write_data),
		.i_byte_enable           (i_byte_enable),
		.i_read_data             (i_read_data),
		.o_exec_valid            (exec_valid),
		.o_exec_rec              (exec_rec),
		.o_mem_valid             (mem_valid),
		.o_mem_rec               (mem_rec)
	);

	always #5 i_clk = ~i_clk;

	// strobe totals, sampled away from the rising edge
	always @(negedge i_clk) begin
		if (!i_rst) begin
			if (exec_valid)
				exec_seen++;
			if (mem_valid)
				mem_seen++;
		end
	end

	task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
			error_count++;
		end
	endtask

	function automatic logic strobe_now();
		if (row_kind == 32'd0)
			return exec_valid;
		return mem_valid;
	endfunction

	function automatic string kind_name();
		if (row_kind == 32'd0)
			return "execute";
		return "memory";
	endfunction

	task automatic drive_idle();
		i_fetch_stall           = 1'b0;
		i_interrupt             = 3'd0;
		i_instruction_valid     = 1'b0;
		i_instruction_undefined = 1'b0;
		i_write_enable          = 1'b0;
		i_data_access           = 1'b0;
	endtask

	task automatic drive_row();
		i_fetch_stall           = row_stall[0];
		i_interrupt             = row_irq[2:0];
		i_instruction_undefined = row_undef[0];
		if (row_kind == 32'd0) begin
			i_instruction_valid   = 1'b1;
			i_instruction         = row_word;
			i_instruction_address = row_data;
		end else begin
			// kind 1 write, 2 read, 3 write with access also high
			i_address      = row_word;
			i_byte_enable  = row_be[3:0];
			i_write_enable = (row_kind != 32'd2);
			i_data_access  = (row_kind != 32'd1);
			// the unused data bus carries the inverse so a wrong pick shows
			i_write_data   = (row_kind == 32'd2) ? ~row_data : row_data;
			i_read_data    = (row_kind == 32'd2) ? row_data : ~row_data;
		end
	endtask

	task automatic check_exec();
		check_field("exec address", exec_rec.address, row_data);
		check_field("exec instruction", exec_rec.instruction, row_word);
		check_field("exec type", {28'h0, exec_rec.insn_type}, exp_type);
		check_field("exec mnemonic", {26'h0, exec_rec.mnemonic}, exp_mn);
		check_field("exec imm32", exec_rec.imm32, exp_imm);
		check_field("exec undefined", {31'h0, exec_rec.undefined}, {31'h0, row_undef[0]});
	endtask

	task automatic check_mem();
		check_field("mem address", mem_rec.address, row_word);
		check_field("mem data", mem_rec.data, exp_data);
		check_field("mem byte enable", {28'h0, mem_rec.byte_enable}, exp_be);
		check_field("mem is_write", {31'h0, mem_rec.is_write}, exp_wr);
	endtask

	task automatic run_row();
		int errors_before;
		int waited;
		logic seen;
		errors_before = error_count;
		@(negedge i_clk);
		drive_row();
		@(negedge i_clk);
		drive_idle();
		waited = 0;
		seen = strobe_now();
		while (!seen && waited < TIMEOUT_CYCLES) begin
			@(negedge i_clk);
			waited++;
			seen = strobe_now();
		end
		if (exp_valid[0]) begin
			if (seen) begin
				check_field("latency", waited, 0);
				if (row_kind == 32'd0)
					check_exec();
				else
					check_mem();
			end else begin
				$display("no %s record arrived within %0d cycles", kind_name(), TIMEOUT_CYCLES);
				error_count++;
			end
		end else if (seen) begin
			$display("an unexpected %s record appeared at %0t", kind_name(), $time);
			error_count++;
		end
		$display("test %0d (%s, word %h): %s", test_count, kind_name(), row_word,
			(error_count == errors_before) ? "ok" : "failed");
	endtask

	initial begin
		int fd;
		int status;
		int fields;
		int line_count;
		string line;
		i_clk = 1'b0;
		i_rst = 1'b1;
		i_instruction         = 32'h0;
		i_instruction_address = 32'h0;
		i_address             = 32'h0;
		i_write_data          = 32'h0;
		i_read_data           = 32'h0;
		i_byte_enable         = 4'h0;
		drive_idle();
		// live requests while reset is high, no strobe may follow
		i_instruction_valid = 1'b1;
		i_write_enable      = 1'b1;
		i_data_access       = 1'b1;
		error_count   = 0;
		test_count    = 0;
		exec_seen     = 0;
		mem_seen      = 0;
		exec_expected = 0;
		mem_expected  = 0;
		line_count    = 0;
		repeat (2) @(posedge i_clk);
		@(negedge i_clk);
		i_rst = 1'b0;
		drive_idle();
		fd = $fopen("tests/trace_input.dat", "r");
		if (fd == 0) begin
			$display("cannot open the vector file tests/trace_input.dat");
			$display("TEST RESULT: FAIL");
			$finish;
		end else begin
			while (!$feof(fd) && line_count < MAX_LINES) begin
				status = $fgets(line, fd);
				line_count++;
				if (status == 0 || line.len() == 0 || line[0] == "#")
					continue;
				fields = $sscanf(line, "%h %h %h %h %h %h %h %d %d %h %h %h %h %h",
					row_kind, row_stall, row_irq, row_undef, row_word, row_data, row_be,
					exp_type, exp_mn, exp_imm, exp_data, exp_be, exp_wr, exp_valid);
				if (fields != 14) begin
					if (fields > 0) begin
						$display("vector line %0d has %0d fields instead of 14", line_count, fields);
						error_count++;
					end
					continue;
				end
				test_count++;
				if (exp_valid[0] && row_kind == 32'd0)
					exec_expected++;
				else if (exp_valid[0])
					mem_expected++;
				run_row();
			end
			$fclose(fd);
			// late strobes would still show up in the totals
			for (int i = 0; i < TIMEOUT_CYCLES; i++)
				@(negedge i_clk);
			@(posedge i_clk);
			check_field("execute record count", exec_seen, exec_expected);
			check_field("memory record count", mem_seen, mem_expected);
			$display("tests %0d, errors %0d", test_count, error_count);
			if (error_count == 0 && test_count > 0)
				$display("TEST RESULT: PASS");
			else
				$display("TEST RESULT: FAIL");
			$finish;
		end
	end

endmodule

// File: tests/trace_input.dat
# kind(0 exec,1 wr,2 rd,3 wr+acc) stall irq undef word data be type(dec) mnem(dec) imm32
# then exp_data exp_be exp_wr expect_record; exec rows use data as the instruction address
0 0 0 0 e0013002 00000100 0 0  3 00000000 00000000 0 0 1
0 0 0 0 e0213002 00000104 0 0 10 00000000 00000000 0 0 1
0 0 0 0 e0413002 00000108 0 0 29 00000000 00000000 0 0 1
0 0 0 0 e0613002 0000010c 0 0 22 00000000 00000000 0 0 1
0 0 0 0 e0813002 00000110 0 0  2 00000000 00000000 0 0 1
0 0 0 0 e0a13002 00000114 0 0  1 00000000 00000000 0 0 1
0 0 0 0 e0c13002 00000118 0 0 24 00000000 00000000 0 0 1
0 0 0 0 e0e13002 0000011c 0 0 23 00000000 00000000 0 0 1
0 0 0 0 e1113002 00000120 0 0 34 00000000 00000000 0 0 1
0 0 0 0 e1313002 00000124 0 0 33 00000000 00000000 0 0 1
0 0 0 0 e1513002 00000128 0 0  9 00000000 00000000 0 0 1
0 0 0 0 e1713002 0000012c 0 0  8 00000000 00000000 0 0 1
0 0 0 0 e1813002 00000130 0 0 21 00000000 00000000 0 0 1
0 0 0 0 e1a13002 00000134 0 0 17 00000000 00000000 0 0 1
0 0 0 0 e1c13002 00000138 0 0  5 00000000 00000000 0 0 1
0 0 0 0 e1e13002 0000013c 0 0 20 00000000 00000000 0 0 1
0 0 0 0 e0000291 00000140 0 1 19 00000000 00000000 0 0 1
0 0 0 0 e0203291 00000144 0 1 16 00000000 00000000 0 0 1
0 0 0 0 e1012093 00000148 0 2 31 00000000 00000000 0 0 1
0 0 0 0 e1412093 0000014c 0 2 32 00000000 00000000 0 0 1
0 0 0 0 e5810000 00000150 0 3 27 00000000 00000000 0 0 1
0 0 0 0 e5910000 00000154 0 3 13 00000000 00000000 0 0 1
0 0 0 0 e5c10000 00000158 0 3 28 00000000 00000000 0 0 1
0 0 0 0 e5d10000 0000015c 0 3 14 00000000 00000000 0 0 1
0 0 0 0 e8810001 00000160 0 4 26 00000000 00000000 0 0 1
0 0 0 0 e8910001 00000164 0 4 12 00000000 00000000 0 0 1
0 0 0 0 ea000004 00000168 0 5  4 00000000 00000000 0 0 1
0 0 0 0 eb000004 0000016c 0 5  6 00000000 00000000 0 0 1
0 0 0 0 ed810100 00000170 0 6 25 00000000 00000000 0 0 1
0 0 0 0 ed910100 00000174 0 6 11 00000000 00000000 0 0 1
0 0 0 0 ee012100 00000178 0 7  7 00000000 00000000 0 0 1
0 0 0 0 ee012110 0000017c 0 8 15 00000000 00000000 0 0 1
0 0 0 0 ee112110 00000180 0 8 18 00000000 00000000 0 0 1
0 0 0 0 ef000011 00000184 0 9 30 00000000 00000000 0 0 1
# unmatched coprocessor space, register operand with rotate bits set
0 0 0 0 efffffff 00000188 0 9 30 00000000 00000000 0 0 1
0 0 0 0 e1a00f02 0000018c 0 0 17 00000000 00000000 0 0 1
# rotated immediates, rot 0 1 4 15
0 0 0 0 e3a000ab 00000190 0 0 17 000000ab 00000000 0 0 1
0 0 0 0 e3a001ab 00000194 0 0 17 c000002a 00000000 0 0 1
0 0 0 0 e3a004ab 00000198 0 0 17 ab000000 00000000 0 0 1
0 0 0 0 e3a00fab 0000019c 0 0 17 000002ac 00000000 0 0 1
0 0 0 0 e2812f7f 000001a0 0 0  2 000001fc 00000000 0 0 1
# stalled then accepted, interrupt levels, undefined flag
0 1 0 0 e0813002 00000200 0 0  2 00000000 00000000 0 0 0
0 0 0 0 e0813002 00000200 0 0  2 00000000 00000000 0 0 1
0 0 3 0 e3a004ab 00000300 0 0 17 ab000000 00000000 0 0 0
0 0 7 0 e3a004ab 00000304 0 0 17 ab000000 00000000 0 0 1
0 0 0 0 e3a004ab 00000308 0 0 17 ab000000 00000000 0 0 1
0 0 0 1 e7f000f0 00000400 0 3 14 00000000 00000000 0 0 1
# memory records
1 0 0 0 00001000 deadbeef 3 0  0 00000000 deadbeef 3 1 1
2 0 0 0 00001004 cafef00d 2 0  0 00000000 cafef00d f 0 1
3 0 0 0 00001008 12345678 f 0  0 00000000 12345678 f 1 1
1 0 0 0 00001011 000000a5 2 0  0 00000000 000000a5 2 1 1
2 1 0 0 0000100c 0badf00d f 0  0 00000000 00000000 0 0 0
1 1 0 0 00001010 55aa55aa 1 0  0 00000000 00000000 0 0 0

// File: sim.f
common/a23_trace_pkg.sv
trace/a23_exec_stage.sv
trace/a23_insn_decoder.sv
trace/a23_mem_monitor.sv
trace/a23_tracer.sv
tests/a23_tracer_asserts.sv
tests/a23_tracer_tb.sv

// File: Makefile
# Verilator build and run of the a23 tracer testbench

VERILATOR ?= verilator
TOP       ?= a23_tracer_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
